//--- sim/decode_tests.txt
# name reset zero ctrl | name write addr data(hex or rand)
# name instr word wen waddr wdata stall flush rd rs1 rs2 f3 f7 imm op1 op2 ctrl
after_reset reset 00000000 070
w_x5 write 05 12345678
w_x6 write 06 ffff0001
r_sub instr 406281b3 0 00 0 0 0 03 05 06 0 20 00000406 reg reg 071
i_addi_neg instr 80028393 0 00 0 0 0 07 05 00 0 40 fffff800 reg reg 171
ld_lb instr 00628403 0 00 0 0 0 08 05 06 0 00 00000006 reg reg 103
ld_lh instr 00629403 0 00 0 0 0 08 05 06 1 00 00000006 reg reg 113
ld_lw instr 0062a403 0 00 0 0 0 08 05 06 2 00 00000006 reg reg 123
ld_lbu instr 0062c403 0 00 0 0 0 08 05 06 4 00 00000006 reg reg 143
ld_lhu instr 0062d403 0 00 0 0 0 08 05 06 5 00 00000006 reg reg 153
st_sb instr fe628c23 0 00 0 0 0 18 05 06 0 7f fffffff8 reg reg 1f4
st_sh instr fe629c23 0 00 0 0 0 18 05 06 1 7f fffffff8 reg reg 1f8
st_sw instr fe62ac23 0 00 0 0 0 18 05 06 2 7f fffffff8 reg reg 1fc
st_reserved instr fe62bc23 0 00 0 0 0 18 05 06 3 7f fffffff8 reg reg 1f0
b_beq_neg instr fe6288e3 0 00 0 0 0 11 05 06 0 7f fffffff0 reg reg 070
j_jal_neg instr 800000ef 0 00 0 0 0 01 00 00 0 40 fff00000 reg reg 171
j_jalr instr 006280e7 0 00 0 0 0 01 05 06 0 00 00000006 reg reg 171
u_lui instr 8062a4b7 0 00 0 0 0 09 05 06 2 40 8062a000 reg reg 171
u_auipc instr 8062a497 0 00 0 0 0 09 05 06 2 40 8062a000 reg reg 171
op_unknown instr 0062807f 0 00 0 0 0 00 05 06 0 00 00000006 reg reg 070
w_x10 write 0a rand
w_x11 write 0b rand
w_x0 write 00 rand
rf_read instr 00b50633 0 00 0 0 0 0c 0a 0b 0 00 0000000b reg reg 071
rf_x0 instr 00a00633 1 00 rand 0 0 0c 00 0a 0 00 0000000a reg reg 071
rf_bypass instr 00a58633 1 0b rand 0 0 0c 0b 0a 0 00 0000000a reg reg 071
rf_after instr 00b586b3 0 00 0 0 0 0d 0b 0b 0 00 0000000b reg reg 071
sf_base instr 0062a403 0 00 0 0 0 08 05 06 2 00 00000006 12345678 ffff0001 123
sf_stall instr 406281b3 0 00 0 1 0 08 05 06 2 00 00000006 12345678 ffff0001 123
sf_flush instr 406281b3 0 00 0 0 1 00 00 00 0 00 00000000 00000000 00000000 070
sf_reload instr 0062a403 0 00 0 0 0 08 05 06 2 00 00000006 12345678 ffff0001 123
sf_both instr 406281b3 0 00 0 1 1 00 00 00 0 00 00000000 00000000 00000000 070

//--- project.f
hdl/rv_pkg.sv
hdl/decode_controller.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/id_ex_reg.sv
hdl/decode_top.sv
sim/clk_gen.sv
sim/decode_tb.sv

//--- sim/decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_tb;
    import rv_pkg::*;

    localparam string TESTS_FILE = "sim/decode_tests.txt";

    logic    clk;
    logic    rst_n;
    instr_t  instruction;
    wb_t     wb;
    logic    stall;
    logic    flush;
    decode_t id_ex;

    string   test_lines[$];
    string   fields[$];

    // Contents the register file should hold, x0 never written
    word_t   reg_model [REG_COUNT];

    // Opcode the pipeline register should hold, kept across stalls
    opcode_t opcode_held = '0;

    int      cycle_count = 0;
    int      cycle_limit = 0;

    clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    decode_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .wb          (wb),
        .stall       (stall),
        .flush       (flush),
        .id_ex       (id_ex)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_word(input string test_name, input string field,
                              input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED %s %s: expected %h, actual %h",
                                        test_name, field, expected, actual));
        end
    endtask

    task automatic check_addr(input string test_name, input string field,
                              input reg_addr_t expected, input reg_addr_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED %s %s: expected %h, actual %h",
                                        test_name, field, expected, actual));
        end
    endtask

    task automatic check_ctrl(input string test_name, input ctrl_t expected,
                              input ctrl_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED %s ctrl: expected %h, actual %h",
                                        test_name, expected, actual));
        end
    endtask

    task automatic check_opcode(input string test_name, input opcode_t expected,
                                input opcode_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED %s opcode: expected %h, actual %h",
                                        test_name, expected, actual));
        end
    endtask

    // func3 is passed zero extended
    task automatic check_func(input string test_name, input string field,
                              input logic [6:0] expected, input logic [6:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED %s %s: expected %h, actual %h",
                                        test_name, field, expected, actual));
        end
    endtask

    task automatic split_fields(input string line);
        int  start;
        byte ch;
        fields.delete();
        start = -1;
        for (int i = 0; i <= line.len(); i++) begin
            if (i == line.len()) begin
                ch = " ";
            end else begin
                ch = line[i];
            end
            if (ch == " " || ch == "\t" || ch == "\n" || ch == "\r") begin
                if (start >= 0) begin
                    fields.push_back(line.substr(start, i - 1));
                    start = -1;
                end
            end else if (start < 0) begin
                start = i;
            end
        end
    endtask

    task automatic load_tests;
        int    fd;
        string line;
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            stop_with_failure($sformatf("Cannot open the tests file %s", TESTS_FILE));
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                split_fields(line);
                if (fields.size() > 0 && fields[0].substr(0, 0) != "#") begin
                    test_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic word_t hex_value(input string s);
        return s.atohex();
    endfunction

    function automatic word_t data_value(input string s);
        if (s == "rand") begin
            return $urandom();
        end
        return hex_value(s);
    endfunction

    // Register read as seen in the decode cycle, including write-through
    function automatic word_t expected_operand(input string s, input reg_addr_t addr,
                                               input wb_t port);
        if (s != "reg") begin
            return hex_value(s);
        end
        if (addr == 5'd0) begin
            return '0;
        end
        if (port.wr_en && port.wr_addr == addr) begin
            return port.wr_data;
        end
        return reg_model[addr];
    endfunction

    task automatic verify_reset_state(input string name);
        word_t zero_exp;
        ctrl_t ctrl_exp;
        zero_exp = hex_value(fields[2]);
        ctrl_exp = ctrl_t'(9'(hex_value(fields[3])));
        check_word(name, "op1", zero_exp, id_ex.op1);
        check_word(name, "op2", zero_exp, id_ex.op2);
        check_word(name, "imm", zero_exp, id_ex.imm);
        check_addr(name, "rd", reg_addr_t'(zero_exp), id_ex.rd);
        check_addr(name, "rs1", reg_addr_t'(zero_exp), id_ex.rs1);
        check_addr(name, "rs2", reg_addr_t'(zero_exp), id_ex.rs2);
        check_opcode(name, opcode_t'(zero_exp), id_ex.opcode);
        check_func(name, "func3", 7'(zero_exp), {4'b0, id_ex.func3});
        check_func(name, "func7", 7'(zero_exp), id_ex.func7);
        check_ctrl(name, ctrl_exp, id_ex.ctrl);
        opcode_held = opcode_t'(zero_exp);
    endtask

    task automatic write_register(input string name);
        reg_addr_t addr;
        word_t     data;
        addr  = reg_addr_t'(hex_value(fields[2]));
        data  = data_value(fields[3]);
        wb    = '{wr_en: 1'b1, wr_addr: addr, wr_data: data};
        stall = 1'b0;
        flush = 1'b0;
        @(negedge clk);
        if (addr != 5'd0) begin
            reg_model[addr] = data;
        end
        // The held instruction was captured at that edge
        opcode_held = instruction[6:0];
        wb.wr_en = 1'b0;
    endtask

    task automatic drive_instruction(input string name);
        wb_t       port;
        reg_addr_t rs1_exp;
        reg_addr_t rs2_exp;
        word_t     op1_exp;
        word_t     op2_exp;
        opcode_t   opcode_exp;
        port.wr_en   = 1'(hex_value(fields[3]));
        port.wr_addr = reg_addr_t'(hex_value(fields[4]));
        port.wr_data = data_value(fields[5]);
        rs1_exp      = reg_addr_t'(hex_value(fields[9]));
        rs2_exp      = reg_addr_t'(hex_value(fields[10]));
        op1_exp      = expected_operand(fields[14], rs1_exp, port);
        op2_exp      = expected_operand(fields[15], rs2_exp, port);
        instruction  = instr_t'(hex_value(fields[2]));
        wb           = port;
        stall        = 1'(hex_value(fields[6]));
        flush        = 1'(hex_value(fields[7]));
        // Bubble on flush, previous slot on stall, else bits 6:0 of the word
        if (flush) begin
            opcode_exp = '0;
        end else if (stall) begin
            opcode_exp = opcode_held;
        end else begin
            opcode_exp = instruction[6:0];
        end
        opcode_held = opcode_exp;
        // Captured at the rising edge, sampled at the next falling edge
        @(negedge clk);
        if (port.wr_en && port.wr_addr != 5'd0) begin
            reg_model[port.wr_addr] = port.wr_data;
        end
        check_addr(name, "rd", reg_addr_t'(hex_value(fields[8])), id_ex.rd);
        check_addr(name, "rs1", rs1_exp, id_ex.rs1);
        check_addr(name, "rs2", rs2_exp, id_ex.rs2);
        check_opcode(name, opcode_exp, id_ex.opcode);
        check_func(name, "func3", 7'(hex_value(fields[11])), {4'b0, id_ex.func3});
        check_func(name, "func7", 7'(hex_value(fields[12])), id_ex.func7);
        check_word(name, "imm", hex_value(fields[13]), id_ex.imm);
        check_word(name, "op1", op1_exp, id_ex.op1);
        check_word(name, "op2", op2_exp, id_ex.op2);
        check_ctrl(name, ctrl_t'(9'(hex_value(fields[16]))), id_ex.ctrl);
    endtask

    task automatic run_line(input string line);
        split_fields(line);
        if (fields.size() == 4 && fields[1] == "reset") begin
            verify_reset_state(fields[0]);
        end else if (fields.size() == 4 && fields[1] == "write") begin
            write_register(fields[0]);
        end else if (fields.size() == 17 && fields[1] == "instr") begin
            drive_instruction(fields[0]);
        end else begin
            stop_with_failure($sformatf("Malformed line in the tests file: %s", line));
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("Timeout, tests did not finish within %0d cycles",
                                        cycle_limit));
        end
    end

    initial begin
        instruction = '0;
        wb          = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        void'($urandom(21));
        load_tests();
        cycle_limit = test_lines.size() * 4 + 100;
        @(posedge rst_n);
        foreach (test_lines[i]) begin
            run_line(test_lines[i]);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, clear of the capturing edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::instr_t  instruction,
    input  rv_pkg::wb_t     wb,
    input  logic            stall,
    input  logic            flush,
    output rv_pkg::decode_t id_ex
);
    import rv_pkg::*;

    // Combinational decode result ahead of the pipeline register
    decode_t dec;

    decode_stage u_decode_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .wb          (wb),
        .dec         (dec)
    );

    id_ex_reg u_id_ex_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .flush  (flush),
        .dec_in (dec),
        .id_ex  (id_ex)
    );

endmodule

`default_nettype wire

//--- hdl/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            flush,
    input  rv_pkg::decode_t dec_in,
    output rv_pkg::decode_t id_ex
);
    import rv_pkg::*;

    // Flush beats stall so a squashed slot never lingers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= DECODE_BUBBLE;
        end else if (flush) begin
            id_ex <= DECODE_BUBBLE;
        end else if (!stall) begin
            id_ex <= dec_in;
        end
    end

    flush_gives_bubble: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> id_ex.ctrl == CTRL_BUBBLE
    ) else $error("id_ex_reg: control not cleared after flush");

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::instr_t  instruction,
    input  rv_pkg::wb_t     wb,
    output rv_pkg::decode_t dec
);
    import rv_pkg::*;

    opcode_t    opcode;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic [2:0] func3;
    logic [6:0] func7;
    word_t      imm;
    word_t      op1;
    word_t      op2;
    ctrl_t      ctrl;

    // Fixed field positions, shared by all formats
    assign opcode = instruction[6:0];
    assign rd     = instruction[11:7];
    assign func3  = instruction[14:12];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];
    assign func7  = instruction[31:25];

    always_comb begin
        case (opcode)
            OPCODE_STYPE: begin
                imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            OPCODE_JTYPE: begin
                imm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
            end
            OPCODE_BTYPE: begin
                imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            end
            OPCODE_UTYPE,
            OPCODE_AUIPC: begin
                imm = {instruction[31:12], 12'h000};
            end
            // I-type layout also covers loads and JALR
            default: begin
                imm = {{20{instruction[31]}}, instruction[31:20]};
            end
        endcase
    end

    decode_controller u_decode_controller (
        .opcode (opcode),
        .func3  (func3),
        .ctrl   (ctrl)
    );

    register_file u_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb       (wb),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .op1      (op1),
        .op2      (op2)
    );

    always_comb begin
        dec        = '0;
        dec.op1    = op1;
        dec.op2    = op2;
        dec.rs1    = rs1;
        dec.rs2    = rs2;
        dec.rd     = rd;
        dec.imm    = imm;
        dec.opcode = opcode;
        dec.func3  = func3;
        dec.func7  = func7;
        dec.ctrl   = ctrl;
    end

endmodule

`default_nettype wire

//--- hdl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::wb_t       wb,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     op1,
    output rv_pkg::word_t     op2
);
    import rv_pkg::*;

    word_t regs [REG_COUNT];

    // x0 is never written, reads of it are forced to zero below
    always_ff @(posedge clk) begin
        if (wb.wr_en && wb.wr_addr != '0) begin
            regs[wb.wr_addr] <= wb.wr_data;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wb.wr_en && wb.wr_addr == addr) begin
            data = wb.wr_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        op1 = read_port(rs1_addr);
        op2 = read_port(rs2_addr);
    end

    wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb.wr_en |-> !$isunknown(wb.wr_addr)
    ) else $error("register_file: write enabled with unknown address");

endmodule

`default_nettype wire

//--- hdl/decode_controller.sv
`timescale 1ns/1ps
`default_nettype none

module decode_controller (
    input  rv_pkg::opcode_t opcode,
    input  logic [2:0]      func3,
    output rv_pkg::ctrl_t   ctrl
);
    import rv_pkg::*;

    // Store width from func3, reserved encodings give no store
    function automatic store_type_t store_width(input logic [2:0] f3);
        store_type_t width;
        case (f3)
            3'b000:  width = STORE_BYTE;
            3'b001:  width = STORE_HALF;
            3'b010:  width = STORE_WORD;
            default: width = STORE_NONE;
        endcase
        return width;
    endfunction

    always_comb begin
        ctrl = CTRL_BUBBLE;
        case (opcode)
            OPCODE_RTYPE: begin
                ctrl.wb_reg_file = 1'b1;
            end
            OPCODE_ITYPE,
            OPCODE_JTYPE,
            OPCODE_JALR,
            OPCODE_UTYPE,
            OPCODE_AUIPC: begin
                ctrl.alu_src     = 1'b1;
                ctrl.wb_reg_file = 1'b1;
            end
            OPCODE_LOAD: begin
                ctrl.alu_src       = 1'b1;
                ctrl.mem_load_type = func3;
                ctrl.wb_load       = 1'b1;
                ctrl.wb_reg_file   = 1'b1;
            end
            OPCODE_STYPE: begin
                ctrl.alu_src        = 1'b1;
                ctrl.mem_write      = 1'b1;
                ctrl.mem_store_type = store_width(func3);
            end
            // Branches and unknown opcodes leave the bubble in place
            default: begin
                ctrl = CTRL_BUBBLE;
            end
        endcase
    end

    // A store never loads back into the register file
    no_store_load: assert final (!(ctrl.mem_write && ctrl.wb_load))
        else $error("decode_controller: store and load both active, opcode %b", opcode);

endmodule

`default_nettype wire

//--- hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  load_type_t;
    typedef logic [1:0]  store_type_t;

    localparam int REG_COUNT = 32;

    // RV32I major opcodes
    localparam opcode_t OPCODE_RTYPE = 7'b0110011;
    localparam opcode_t OPCODE_ITYPE = 7'b0010011;
    localparam opcode_t OPCODE_LOAD  = 7'b0000011;
    localparam opcode_t OPCODE_STYPE = 7'b0100011;
    localparam opcode_t OPCODE_BTYPE = 7'b1100011;
    localparam opcode_t OPCODE_JTYPE = 7'b1101111;
    localparam opcode_t OPCODE_JALR  = 7'b1100111;
    localparam opcode_t OPCODE_UTYPE = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC = 7'b0010111;

    // Load types other than NONE are the load's func3
    localparam load_type_t LOAD_NONE = 3'b111;

    localparam store_type_t STORE_NONE = 2'b00;
    localparam store_type_t STORE_BYTE = 2'b01;
    localparam store_type_t STORE_HALF = 2'b10;
    localparam store_type_t STORE_WORD = 2'b11;

    typedef struct packed {
        logic        alu_src;
        logic        mem_write;
        load_type_t  mem_load_type;
        store_type_t mem_store_type;
        logic        wb_load;
        logic        wb_reg_file;
    } ctrl_t;

    localparam ctrl_t CTRL_BUBBLE = '{
        alu_src:        1'b0,
        mem_write:      1'b0,
        mem_load_type:  LOAD_NONE,
        mem_store_type: STORE_NONE,
        wb_load:        1'b0,
        wb_reg_file:    1'b0
    };

    // Writeback port into the register file
    typedef struct packed {
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     wr_data;
    } wb_t;

    typedef struct packed {
        word_t     op1;
        word_t     op2;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        opcode_t   opcode;
        logic [2:0] func3;
        logic [6:0] func7;
        ctrl_t     ctrl;
    } decode_t;

    // Empty pipeline slot, everything zero but with inactive control
    localparam decode_t DECODE_BUBBLE = '{ctrl: CTRL_BUBBLE, default: '0};

endpackage

`default_nettype wire
